/* hw/mmsa_settings.svh */
`ifndef MMSA_SETTINGS_SVH
`define MMSA_SETTINGS_SVH

// matrix geometry, fixed at build time
`define MMSA_MAT_DIM 4

// number of stored X matrices, and of stored W matrices
`define MMSA_MAT_COUNT 4

// signed entry width
`define MMSA_ELEM_W 16

// lane partial sums and the output value
`define MMSA_SUM_W 40

// matrix index, log2 of the matrix count
`define MMSA_IDX_W 2

`endif

/* hw/mmsa_pkg.sv */
`default_nettype none

`include "mmsa_settings.svh"

package mmsa_pkg;

    // one signed matrix entry
    typedef logic signed [`MMSA_ELEM_W-1:0] elem_t;

    // partial or final sum
    typedef logic signed [`MMSA_SUM_W-1:0] sum_t;

    // selects one stored matrix
    typedef logic [`MMSA_IDX_W-1:0] mat_idx_t;

    // a whole W row, element j in bits [j*ELEM_W +: ELEM_W]
    typedef logic [`MMSA_MAT_DIM*`MMSA_ELEM_W-1:0] weight_row_t;

    typedef enum logic [1:0] {
        FEED_IDLE,
        FEED_LOAD,
        FEED_RUN
    } feed_state_t;

endpackage

`default_nettype wire

/* hw/operand_feeder.sv */
`default_nettype none

`include "mmsa_settings.svh"

module operand_feeder
    import mmsa_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic        in_valid2,
    input  elem_t       matrix,
    input  mat_idx_t    i_mat_idx,
    input  mat_idx_t    w_mat_idx,
    output weight_row_t weight_rows [`MMSA_MAT_DIM],
    output elem_t       lane_x [`MMSA_MAT_DIM],
    output logic        feed_valid
);

    localparam int DIM       = `MMSA_MAT_DIM;
    localparam int POS_W     = $clog2(DIM);
    localparam int CNT_W     = 1 + `MMSA_IDX_W + 2 * POS_W;
    localparam int LAST_STEP = 2 * DIM;
    localparam int STEP_W    = $clog2(LAST_STEP + 1);

    // ------------------------------------------------------------------
    // storage and load addressing
    // ------------------------------------------------------------------
    elem_t x_mem [`MMSA_MAT_COUNT][DIM][DIM];
    elem_t w_mem [`MMSA_MAT_COUNT][DIM][DIM];

    feed_state_t state, state_nxt;

    logic [CNT_W-1:0]  load_cnt;
    logic              load_is_w;
    mat_idx_t          load_mat;
    logic [POS_W-1:0]  load_row;
    logic [POS_W-1:0]  load_col;
    logic              load_wr;
    logic              last_entry;
    logic              loaded;

    logic              run_start;
    mat_idx_t          x_sel;
    mat_idx_t          w_sel;
    logic [STEP_W-1:0] step;
    logic [POS_W-1:0]  feed_row;
    logic              feed_row_on;
    logic              feed_on;

    // top bit picks X or W, then matrix, row, column
    assign {load_is_w, load_mat, load_row, load_col} = load_cnt;

    assign load_wr    = in_valid && (state != FEED_RUN);
    assign last_entry = &load_cnt;

    // only after a full load, and never mid-computation
    assign run_start = (state == FEED_IDLE) && in_valid2 && !in_valid && loaded;

    always_ff @(posedge clk) begin
        if (load_wr) begin
            if (load_is_w) begin
                w_mem[load_mat][load_row][load_col] <= matrix;
            end else begin
                x_mem[load_mat][load_row][load_col] <= matrix;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_cnt <= '0;
            loaded   <= 1'b0;
        end else if (load_wr) begin
            load_cnt <= load_cnt + 1'b1;
            if (last_entry) begin
                loaded <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            FEED_IDLE: begin
                if (in_valid) begin
                    state_nxt = FEED_LOAD;
                end else if (run_start) begin
                    state_nxt = FEED_RUN;
                end
            end
            FEED_LOAD: begin
                if (in_valid && last_entry) begin
                    state_nxt = FEED_IDLE;
                end
            end
            FEED_RUN: begin
                if (step == STEP_W'(LAST_STEP)) begin
                    state_nxt = FEED_IDLE;
                end
            end
            default: state_nxt = FEED_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FEED_IDLE;
            step  <= '0;
            x_sel <= '0;
            w_sel <= '0;
        end else begin
            state <= state_nxt;
            if (run_start) begin
                x_sel <= i_mat_idx;
                w_sel <= w_mat_idx;
            end
            if (state == FEED_RUN && step != STEP_W'(LAST_STEP)) begin
                step <= step + 1'b1;
            end else begin
                step <= '0;
            end
        end
    end

    // ------------------------------------------------------------------
    // operand streaming
    // ------------------------------------------------------------------
    // step 1..DIM carries X rows, the rest of the window flushes zeros
    assign feed_row    = POS_W'(step - 1'b1);
    assign feed_row_on = (state == FEED_RUN) && (step != '0) && (step <= STEP_W'(DIM));
    assign feed_on     = (state == FEED_RUN) && (step != '0) && (step < STEP_W'(LAST_STEP));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < DIM; r++) begin
                weight_rows[r] <= '0;
                lane_x[r]      <= '0;
            end
            feed_valid <= 1'b0;
        end else begin
            // W rows are captured once, right after the start edge
            if (state == FEED_RUN && step == '0) begin
                for (int r = 0; r < DIM; r++) begin
                    for (int j = 0; j < DIM; j++) begin
                        weight_rows[r][j*`MMSA_ELEM_W +: `MMSA_ELEM_W] <= w_mem[w_sel][r][j];
                    end
                end
            end
            for (int r = 0; r < DIM; r++) begin
                lane_x[r] <= feed_row_on ? x_mem[x_sel][feed_row][r] : '0;
            end
            feed_valid <= feed_on;
        end
    end

endmodule

`default_nettype wire

/* hw/array_lane.sv */
`default_nettype none

`include "mmsa_settings.svh"

module array_lane
    import mmsa_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  weight_row_t weight_row,
    input  elem_t       x_in,
    output sum_t        lane_sum
);

    localparam int DIM    = `MMSA_MAT_DIM;
    localparam int PROD_W = 2 * `MMSA_ELEM_W;

    // one product per tap, widened to the sum width
    sum_t prod  [DIM];
    sum_t chain [DIM];

    genvar k;
    generate
        for (k = 0; k < DIM; k++) begin : g_tap
            elem_t                    w_k;
            logic signed [PROD_W-1:0] mul;

            assign w_k     = elem_t'(weight_row[k*`MMSA_ELEM_W +: `MMSA_ELEM_W]);
            assign mul     = x_in * w_k;
            assign prod[k] = sum_t'(mul);
        end
    endgenerate

    // transposed FIR, tap k holds W[r][k]
    // chain[0] after step t is the sum of x(t-k)*w[k]
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DIM; i++) begin
                chain[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DIM - 1; i++) begin
                chain[i] <= prod[i] + chain[i+1];
            end
            // tail tap has nothing behind it
            chain[DIM-1] <= prod[DIM-1];
        end
    end

    assign lane_sum = chain[0];

endmodule

`default_nettype wire

/* hw/diagonal_summer.sv */
`default_nettype none

`include "mmsa_settings.svh"

module diagonal_summer
    import mmsa_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  sum_t lane_sum [`MMSA_MAT_DIM],
    input  logic feed_valid,
    output logic out_valid,
    output sum_t out_value
);

    logic valid_d;
    sum_t tree_sum;

    // ------------------------------------------------------------------
    // reduction across lanes
    // ------------------------------------------------------------------
    always_comb begin
        tree_sum = '0;
        for (int r = 0; r < `MMSA_MAT_DIM; r++) begin
            tree_sum = tree_sum + lane_sum[r];
        end
    end

    // ------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------
    // lane sums trail the feed by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d   <= 1'b0;
            out_valid <= 1'b0;
            out_value <= '0;
        end else begin
            valid_d   <= feed_valid;
            out_valid <= valid_d;
            // value forced to zero outside the burst
            out_value <= valid_d ? tree_sum : '0;
        end
    end

endmodule

`default_nettype wire

/* hw/mmsa_top.sv */
`default_nettype none

`include "mmsa_settings.svh"

module mmsa_top
    import mmsa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  logic     in_valid2,
    input  elem_t    matrix,
    input  mat_idx_t i_mat_idx,
    input  mat_idx_t w_mat_idx,
    output logic     out_valid,
    output sum_t     out_value
);

    // feeder to lanes
    weight_row_t weight_rows [`MMSA_MAT_DIM];
    elem_t       lane_x      [`MMSA_MAT_DIM];
    logic        feed_valid;

    // lanes to summer
    sum_t        lane_sum    [`MMSA_MAT_DIM];

    // ------------------------------------------------------------------
    // operand storage and sequencing
    // ------------------------------------------------------------------
    operand_feeder u_feeder (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_valid2   (in_valid2),
        .matrix      (matrix),
        .i_mat_idx   (i_mat_idx),
        .w_mat_idx   (w_mat_idx),
        .weight_rows (weight_rows),
        .lane_x      (lane_x),
        .feed_valid  (feed_valid)
    );

    // ------------------------------------------------------------------
    // systolic lanes, lane r takes X column r and W row r
    // ------------------------------------------------------------------
    genvar r;
    generate
        for (r = 0; r < `MMSA_MAT_DIM; r++) begin : g_lane
            array_lane u_lane (
                .clk        (clk),
                .rst_n      (rst_n),
                .weight_row (weight_rows[r]),
                .x_in       (lane_x[r]),
                .lane_sum   (lane_sum[r])
            );
        end
    endgenerate

    // ------------------------------------------------------------------
    // anti-diagonal reduction and output stream
    // ------------------------------------------------------------------
    diagonal_summer u_summer (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_sum   (lane_sum),
        .feed_valid (feed_valid),
        .out_valid  (out_valid),
        .out_value  (out_value)
    );

endmodule

`default_nettype wire

/* testbench/mmsa_properties.sv */
`default_nettype none

`include "mmsa_settings.svh"

module mmsa_properties
    import mmsa_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_valid2,
    input logic out_valid,
    input sum_t out_value
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LOAD_LEN = 2 * `MMSA_MAT_COUNT * `MMSA_MAT_DIM * `MMSA_MAT_DIM;
    localparam int NUM_OUT  = 2 * `MMSA_MAT_DIM - 1;
    // feeder busy from the start edge until feed_valid ends
    localparam int BUSY_LEN = 2 * `MMSA_MAT_DIM + 1;

    logic       loaded;
    logic       accepted;
    logic [4:0] accept_dly;
    int         in_cnt;
    int         busy;
    int         run_len;
    int         load_fails = 0;
    int         len_fails = 0;
    int         start_fails = 0;
    int         zero_fails = 0;
    int         fail_total;

    // in_valid2 counts only when idle after a complete load
    assign accepted   = in_valid2 && !in_valid && loaded && (busy == 0);
    assign fail_total = load_fails + len_fails + start_fails + zero_fails;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_cnt     <= 0;
            loaded     <= 1'b0;
            busy       <= 0;
            run_len    <= 0;
            accept_dly <= '0;
        end else begin
            if (in_valid) begin
                in_cnt <= (in_cnt == LOAD_LEN - 1) ? 0 : in_cnt + 1;
                if (in_cnt == LOAD_LEN - 1) begin
                    loaded <= 1'b1;
                end
            end
            busy       <= accepted ? BUSY_LEN : ((busy > 0) ? busy - 1 : 0);
            run_len    <= out_valid ? run_len + 1 : 0;
            accept_dly <= {accept_dly[3:0], accepted};
        end
    end

    // ------------------------------------------------------------------
    // output stream rules
    // ------------------------------------------------------------------
    quiet_during_load: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !out_valid)
        else begin
            $error("out_valid high while matrices are loading");
            load_fails++;
        end

    burst_length: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid |-> run_len < NUM_OUT) and ($fell(out_valid) |-> run_len == NUM_OUT))
        else begin
            $error("out_valid run is not %0d cycles long", NUM_OUT);
            len_fails++;
        end

    // rise seen one sample after the 4th edge
    burst_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid) == accept_dly[4])
        else begin
            $error("out_valid did not rise 4 edges after an accepted in_valid2");
            start_fails++;
        end

    zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_value == '0)
        else begin
            $error("out_value nonzero while out_valid is low");
            zero_fails++;
        end

endmodule

bind mmsa_top mmsa_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_valid2 (in_valid2),
    .out_valid (out_valid),
    .out_value (out_value)
);

`default_nettype wire

/* testbench/mmsa_tb.sv */
`default_nettype none

`include "mmsa_settings.svh"

module mmsa_tb
    import mmsa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIM        = `MMSA_MAT_DIM;
    localparam int MATS       = `MMSA_MAT_COUNT;
    localparam int NUM_OUT    = 2 * DIM - 1;
    localparam int WAIT_LIMIT = 12;
    localparam int NUM_TESTS  = 5;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_valid2;
    elem_t    matrix;
    mat_idx_t i_mat_idx;
    mat_idx_t w_mat_idx;
    logic     out_valid;
    sum_t     out_value;

    int     seed = 32'hd14e_f91e;
    int     errors;
    int     checks;
    int     bursts;
    int     bad_bursts;
    longint x_ref    [MATS][DIM][DIM];
    longint w_ref    [MATS][DIM][DIM];
    longint expected [NUM_OUT];

    mmsa_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_valid2 (in_valid2),
        .matrix    (matrix),
        .i_mat_idx (i_mat_idx),
        .w_mat_idx (w_mat_idx),
        .out_valid (out_valid),
        .out_value (out_value)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // W0 is the identity while X3 and W3 hold the most negative entry
    task automatic make_matrices();
        for (int m = 0; m < MATS; m++) begin
            for (int i = 0; i < DIM * DIM; i++) begin
                x_ref[m][i / DIM][i % DIM] = longint'(elem_t'($random(seed)));
                w_ref[m][i / DIM][i % DIM] = longint'(elem_t'($random(seed)));
            end
        end
        for (int i = 0; i < DIM * DIM; i++) begin
            w_ref[0][i / DIM][i % DIM] = longint'((i / DIM) == (i % DIM));
            x_ref[3][i / DIM][i % DIM] = -64'sd32768;
            w_ref[3][i / DIM][i % DIM] = -64'sd32768;
        end
    endtask

    // X entries of all matrices first, then W, each row-major
    function automatic elem_t stream_entry(input int n);
        int m;
        int pos;
        m   = (n % (MATS * DIM * DIM)) / (DIM * DIM);
        pos = n % (DIM * DIM);
        if (n < MATS * DIM * DIM) begin
            return elem_t'(x_ref[m][pos / DIM][pos % DIM]);
        end else begin
            return elem_t'(w_ref[m][pos / DIM][pos % DIM]);
        end
    endfunction

    // direct picks the anti-diagonals of X itself, else those of X times W
    function automatic void fill_expected(input int xi, input int wi, input logic direct);
        longint p;
        for (int k = 0; k < NUM_OUT; k++) begin
            expected[k] = '0;
        end
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                p = '0;
                for (int r = 0; r < DIM; r++) begin
                    p += x_ref[xi][i][r] * w_ref[wi][r][j];
                end
                expected[i + j] += direct ? x_ref[xi][i][j] : p;
            end
        end
    endfunction

    // ------------------------------------------------------------------
    // stimulus and checking
    // ------------------------------------------------------------------
    task automatic check_output(input logic exp_valid, input sum_t exp_value);
        checks++;
        assert (out_valid === exp_valid) else begin
            $display("MISMATCH t=%0t out_valid expected %0b actual %0b",
                     $time, exp_valid, out_valid);
            errors++;
        end
        assert (out_value === exp_value) else begin
            $display("MISMATCH t=%0t out_value expected %0d actual %0d",
                     $time, exp_value, out_value);
            errors++;
        end
    endtask

    task automatic start_compute(input int xi, input int wi);
        @(posedge clk);
        in_valid2 <= 1'b1;
        i_mat_idx <= mat_idx_t'(xi);
        w_mat_idx <= mat_idx_t'(wi);
        @(posedge clk);
        in_valid2 <= 1'b0;
    endtask

    task automatic collect_burst();
        int waited;
        int count;
        int high;
        waited = 0;
        count  = 0;
        high   = 0;
        @(negedge clk);
        while (!out_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            $display("no output arrived within %0d cycles of in_valid2", WAIT_LIMIT);
            errors++;
            bad_bursts++;
        end else begin
            while (count < NUM_OUT) begin
                if (out_valid === 1'b1) begin
                    high++;
                end
                check_output(1'b1, sum_t'(expected[count]));
                count++;
                @(negedge clk);
            end
            if (high != NUM_OUT || out_valid) begin
                $display("burst %0d did not last exactly %0d outputs", bursts, NUM_OUT);
                errors++;
                bad_bursts++;
            end
        end
        bursts++;
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_output(1'b0, '0);
        end
    endtask

    task automatic report_test(input int n, input string name, input int errs);
        $display("test %0d %s: %s (%0d errors)", n, name, errs == 0 ? "ok" : "FAILED", errs);
    endtask

    initial begin
        int base;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_valid2  = 1'b0;
        matrix     = '0;
        i_mat_idx  = '0;
        w_mat_idx  = '0;
        errors     = 0;
        checks     = 0;
        bursts     = 0;
        bad_bursts = 0;
        make_matrices();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // outputs quiet after reset and through the load
        base = errors;
        @(negedge clk);
        check_output(1'b0, '0);
        for (int n = 0; n < 2 * MATS * DIM * DIM; n++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            matrix   <= stream_entry(n);
            @(negedge clk);
            check_output(1'b0, '0);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        matrix   <= '0;
        report_test(1, "reset and load", errors - base);

        base = errors;
        for (int xi = 0; xi < MATS; xi++) begin
            fill_expected(xi, 0, 1'b1);
            start_compute(xi, 0);
            collect_burst();
        end
        report_test(2, "identity weights", errors - base);

        base = errors;
        for (int xi = 0; xi < MATS; xi++) begin
            for (int wi = 0; wi < MATS; wi++) begin
                fill_expected(xi, wi, 1'b0);
                start_compute(xi, wi);
                collect_burst();
            end
        end
        report_test(3, "all index pairs", errors - base);

        // extra pulses are sampled 2 and 9 edges after the accepted start
        base = errors;
        fill_expected(2, 3, 1'b0);
        start_compute(2, 3);
        fork
            collect_burst();
            begin
                start_compute(1, 1);
                repeat (5) @(posedge clk);
                start_compute(0, 2);
            end
        join
        check_quiet(3 * NUM_OUT);
        fill_expected(1, 2, 1'b0);
        start_compute(1, 2);
        collect_burst();
        report_test(4, "in_valid2 while busy", errors - base);

        report_test(5, "burst length", bad_bursts);
        $display("tests %0d, bursts %0d, checks %0d, errors %0d, property failures %0d",
                 NUM_TESTS, bursts, checks, errors, DUT.u_props.fail_total);
        if (errors == 0 && DUT.u_props.fail_total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
hw/mmsa_pkg.sv
hw/operand_feeder.sv
hw/array_lane.sv
hw/diagonal_summer.sv
hw/mmsa_top.sv
testbench/mmsa_properties.sv
testbench/mmsa_tb.sv

/* Makefile */
# Verilator build and run for the matrix-multiply engine

VERILATOR ?= verilator
TOP       ?= mmsa_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_FLAGS ?= +verilator+error+limit+1000
LOG       ?= sim.log
FILELIST  ?= all.f

SOURCES   := $(shell grep -v '^+' $(FILELIST)) hw/mmsa_settings.svh
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Checks failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	elif [ $$status -ne 0 ]; then \
		echo "simulator exited with status $$status"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
